// ==== build.f ====
+incdir+include
verilog/host_pkg.sv
verilog/core_pkg.sv
verilog/host_ctrl_decode.sv
verilog/reset_sequencer.sv
verilog/loader_write_buffer.sv
verilog/audio_output.sv
verilog/x68_glue_top.sv
test/x68_glue_sva.sv
test/x68_glue_tb.sv

// ==== Makefile ====
# Verilator flow for the x68 glue testbench

TOP_TB := x68_glue_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Iinclude verilog/host_pkg.sv verilog/core_pkg.sv \
		verilog/host_ctrl_decode.sv verilog/reset_sequencer.sv \
		verilog/loader_write_buffer.sv verilog/audio_output.sv \
		verilog/x68_glue_top.sv --top-module x68_glue_top
	verilator --lint-only --timing -f build.f --top-module $(TOP_TB)

sim:
	verilator --binary --timing -f build.f --top-module $(TOP_TB) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP_TB))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir

// ==== test/x68_glue_tb.sv ====
// Inputs change 1 ns after the rising edge; the mount hold test runs about 66k cycles
`timescale 1ns/1ps

module x68_glue_tb;
	import host_pkg::*;
	import core_pkg::*;

	logic                 clk_sys;
	logic                 reset_delayed;
	status_word_u         status;
	logic [1:0]           buttons;
	joy_raw_t             joy0;
	joy_raw_t             joy1;
	dl_in_t               dl;
	logic                 hdd_mounted;
	logic                 ldr_ack;
	sample_t              aud_l;
	sample_t              aud_r;
	core_ctrl_t           core_ctrl;
	joy_port_t            joy_a;
	joy_port_t            joy_b;
	ldr_req_t             ldr;
	logic                 core_rstn;
	logic                 led;
	logic [1:0]           opm_ce;
	logic                 audio_l;
	logic                 audio_r;
	int                   errors;
	int                   test_errors;
	int                   tests_run;
	logic [31:0]          rng;
	longint               cycle;

	x68_glue_top uut (
		.clk_sys(clk_sys), .reset_delayed(reset_delayed), .status_i(status),
		.buttons_i(buttons), .joystick_0_i(joy0), .joystick_1_i(joy1), .dl_i(dl),
		.hdd_mounted_i(hdd_mounted), .ldr_ack_i(ldr_ack), .aud_l_i(aud_l),
		.aud_r_i(aud_r), .core_ctrl_o(core_ctrl), .joy_a_o(joy_a), .joy_b_o(joy_b),
		.ldr_o(ldr), .core_rstn_o(core_rstn), .led_o(led), .opm_ce_o(opm_ce),
		.audio_l_o(audio_l), .audio_r_o(audio_r)
	);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) cycle <= cycle + 1;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Settings as the host bit map defines them
	function automatic logic [13:0] expected_ctrl(input logic [63:0] s);
		return {s[1], ~s[3], s[11:10], s[13:12], s[16:15], ~s[7], ~s[8], s[13], s[14]};
	endfunction

	function automatic logic [5:0] fold_joy(input logic [15:0] r);
		return ~{r[5], r[4], r[0] | r[6], r[1] | r[6], r[2] | r[7], r[3] | r[7]};
	endfunction

	task automatic step(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp, input int tol = 0);
		logic [63:0] diff;
		diff = (got > exp) ? got - exp : exp - got;
		if ($isunknown(got) || diff > 64'(tol)) begin
			$display("CHECK FAILED t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	// Polls one output until it reaches the level or the limit runs out
	task automatic wait_signal(input int sel, input logic level, input int limit,
		input string what);
		logic now;
		for (int i = 0; i < limit; i++) begin
			case (sel)
				0: now = ldr.wr;
				1: now = ldr.done;
				2: now = core_rstn;
				3: now = opm_ce[0];
				default: now = opm_ce[1];
			endcase
			if (now === level)
				return;
			step(1);
		end
		$display("Timeout after %0d cycles waiting for %s", limit, what);
		errors++;
		test_errors++;
	endtask

	task automatic apply_reset();
		status        = '0;
		buttons       = '0;
		dl            = '0;
		hdd_mounted   = 1'b0;
		ldr_ack       = 1'b0;
		reset_delayed = 1'b1;
		step(2);
		reset_delayed = 1'b0;
		step(1);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		$display("Test %0d %s finished with %0d errors", tests_run, name, test_errors);
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus tables
	logic [63:0] status_tbl [6] = '{64'h0, '1, 64'h2000, 64'h0001_8C8A,
		64'h4182, 64'h0001_6C0A};
	logic [15:0] joy_tbl [8][2];
	logic [23:0] ldr_addr_tbl [4] = '{24'h000000, 24'h0F1234, 24'hA5FFFF, 24'h3ABCDE};
	logic [7:0]  ldr_data_tbl [4] = '{8'h00, 8'hA5, 8'hFF, 8'h3C};
	logic [15:0] smp_tbl [5] = '{16'h0000, 16'h8000, 16'h7FFF, 16'h1234, 16'hFC18};

	initial begin
		int ones_l;
		int ones_r;
		int exp_l;
		int exp_r;
		longint last;
		clk_sys     = 1'b0;
		cycle       = 0;
		errors      = 0;
		test_errors = 0;
		tests_run   = 0;
		rng         = 32'd4;
		joy0        = '0;
		joy1        = '0;
		aud_l       = '0;
		aud_r       = '0;
		apply_reset();

		// Settings decode
		foreach (status_tbl[i]) begin
			status = status_tbl[i];
			step(2);
			check_value("core_ctrl_o", 64'(core_ctrl), 64'(expected_ctrl(status_tbl[i])));
		end
		end_test("settings decode");

		// Joystick mapping with both swap states
		foreach (joy_tbl[i]) begin
			rng = xorshift(rng);
			joy_tbl[i][0] = rng[15:0];
			joy_tbl[i][1] = rng[31:16];
		end
		foreach (joy_tbl[i]) begin
			status = '0;
			status[6] = i[0];
			joy0 = joy_tbl[i][0];
			joy1 = joy_tbl[i][1];
			step(2);
			check_value("joy_a_o", 64'(joy_a), 64'(fold_joy(joy_tbl[i][i[0] ? 0 : 1])));
			check_value("joy_b_o", 64'(joy_b), 64'(fold_joy(joy_tbl[i][i[0] ? 1 : 0])));
		end
		end_test("joystick mapping");

		//////////////////////////////////////////////////////////////////////
		// Reset sequencing
		apply_reset();
		check_value("core_rstn_o", 64'(core_rstn), 64'd0);
		dl.download = 1'b1;
		step(10);
		check_value("core_rstn_o", 64'(core_rstn), 64'd0);
		status[0] = 1'b1;
		step(1);
		status[0] = 1'b0;
		wait_signal(2, 1'b1, 20, "core reset release after host reset");
		buttons[1] = 1'b1;
		wait_signal(2, 1'b0, 5, "core reset on button");
		buttons[1] = 1'b0;
		wait_signal(2, 1'b1, 5, "core reset release after button");
		hdd_mounted = 1'b1;
		step(1);
		hdd_mounted = 1'b0;
		step(1000);
		check_value("core_rstn_o", 64'(core_rstn), 64'd0);
		wait_signal(2, 1'b1, 70000, "core reset release after mount hold");
		dl.download = 1'b0;
		end_test("reset sequencing");

		// Loader writes and acknowledge
		apply_reset();
		dl.download = 1'b1;
		step(3);
		check_value("led_o", 64'(led), 64'(!dl.download));
		foreach (ldr_addr_tbl[i]) begin
			dl.wr   = 1'b1;
			dl.addr = ldr_addr_tbl[i];
			dl.data = ldr_data_tbl[i];
			step(1);
			dl.wr = 1'b0;
			wait_signal(0, 1'b1, 10, "loader write request");
			check_value("ldr_o.addr", 64'(ldr.addr), 64'(ldr_addr_tbl[i][19:0]));
			check_value("ldr_o.data", 64'(ldr.data), 64'(ldr_data_tbl[i]));
			check_value("ldr_o.aen", 64'(ldr.aen), 64'd1);
			ldr_ack = 1'b1;
			wait_signal(0, 1'b0, 10, "loader write clear");
			ldr_ack = 1'b0;
			step(3);
		end
		dl.download = 1'b0;
		wait_signal(1, 1'b1, 10, "loader done");
		step(1);
		check_value("ldr_o.aen", 64'(ldr.aen), 64'd0);
		check_value("led_o", 64'(led), 64'(!dl.download));
		dl.wr = 1'b1;
		step(1);
		dl.wr = 1'b0;
		step(4);
		check_value("ldr_o.wr", 64'(ldr.wr), 64'd0);
		end_test("loader");

		// Clock enable periods
		for (int b = 0; b < 2; b++) begin
			wait_signal(3 + b, 1'b1, 40, "opm_ce pulse");
			last = cycle;
			for (int k = 0; k < 3; k++) begin
				step(1);
				wait_signal(3 + b, 1'b1, 40, "opm_ce pulse");
				check_value(b ? "opm_ce_o[1] gap" : "opm_ce_o[0] gap", cycle - last,
					b ? 64'd20 : 64'd16);
				last = cycle;
			end
		end
		end_test("clock enables");

		//////////////////////////////////////////////////////////////////////
		// DAC pulse density
		foreach (smp_tbl[i]) begin
			aud_l = smp_tbl[i];
			aud_r = smp_tbl[(i + 2) % 5];
			step(3);
			ones_l = 0;
			ones_r = 0;
			for (int k = 0; k < 1024; k++) begin
				ones_l += int'(audio_l);
				ones_r += int'(audio_r);
				step(1);
			end
			exp_l = int'((smp_tbl[i] ^ 16'h8000) >> 6);
			exp_r = int'((smp_tbl[(i + 2) % 5] ^ 16'h8000) >> 6);
			// Within one count of the ideal density is accepted
			check_value("audio_l_o ones", 64'(ones_l), 64'(exp_l), 1);
			check_value("audio_r_o ones", 64'(ones_r), 64'(exp_r), 1);
		end
		end_test("delta-sigma DACs");

		$display("Ran %0d tests with %0d errors", tests_run, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== test/x68_glue_sva.sv ====
// Bound to the loader and the audio block; LDR_CHK picks the rules that each instance checks
`timescale 1ns/1ps

module x68_glue_sva #(
	parameter bit LDR_CHK = 1'b1
) (
	input logic clk_sys,
	input logic reset_delayed,
	input logic ldr_wr_i,
	input logic ldr_done_i,
	input logic ldr_aen_i,
	input logic opm_ce_hi_i
);

	if (LDR_CHK) begin : g_ldr
		// No pending write once the download has ended
		wr_after_done: assert property (@(posedge clk_sys) disable iff (reset_delayed)
			!(ldr_wr_i && ldr_done_i))
			else $error("loader write high while done is set");

		aen_after_done: assert property (@(posedge clk_sys) disable iff (reset_delayed)
			!(ldr_aen_i && ldr_done_i))
			else $error("loader address enable high while done is set");
	end else begin : g_opm
		// Divided enable is a single-cycle pulse
		opm_ce_single: assert property (@(posedge clk_sys) disable iff (reset_delayed)
			!(opm_ce_hi_i && $past(opm_ce_hi_i)))
			else $error("opm_ce bit 1 high on two consecutive cycles");
	end

endmodule

bind loader_write_buffer x68_glue_sva #(.LDR_CHK(1'b1)) u_ldr_sva (
	.clk_sys      (clk_sys),
	.reset_delayed(reset_delayed),
	.ldr_wr_i     (ldr_o.wr),
	.ldr_done_i   (ldr_o.done),
	.ldr_aen_i    (ldr_o.aen),
	.opm_ce_hi_i  (1'b0)
);

bind audio_output x68_glue_sva #(.LDR_CHK(1'b0)) u_aud_sva (
	.clk_sys      (clk_sys),
	.reset_delayed(reset_delayed),
	.ldr_wr_i     (1'b0),
	.ldr_done_i   (1'b0),
	.ldr_aen_i    (1'b0),
	.opm_ce_hi_i  (opm_ce_o[1])
);

// ==== verilog/x68_glue_top.sv ====
// Single clk_sys domain; led_o is the only unregistered output and follows the raw download level
`timescale 1ns/1ps

module x68_glue_top (
	input  logic                   clk_sys,
	input  logic                   reset_delayed,
	input  host_pkg::status_word_u status_i,
	input  logic [1:0]             buttons_i,
	input  host_pkg::joy_raw_t     joystick_0_i,
	input  host_pkg::joy_raw_t     joystick_1_i,
	input  host_pkg::dl_in_t       dl_i,
	input  logic                   hdd_mounted_i,
	input  logic                   ldr_ack_i,
	input  core_pkg::sample_t      aud_l_i,
	input  core_pkg::sample_t      aud_r_i,
	output core_pkg::core_ctrl_t   core_ctrl_o,
	output core_pkg::joy_port_t    joy_a_o,
	output core_pkg::joy_port_t    joy_b_o,
	output core_pkg::ldr_req_t     ldr_o,
	output logic                   core_rstn_o,
	output logic                   led_o,
	output logic [1:0]             opm_ce_o,
	output logic                   audio_l_o,
	output logic                   audio_r_o
);
	import host_pkg::*;

	dl_in_t dl_q;
	logic   rst_req;
	logic   host_rst;

	// LED lit while idle, dark during a download
	assign led_o = ~dl_i.download;

	host_ctrl_decode u_decode (
		.clk_sys      (clk_sys),
		.reset_delayed(reset_delayed),
		.status_i     (status_i),
		.buttons_i    (buttons_i),
		.joystick_0_i (joystick_0_i),
		.joystick_1_i (joystick_1_i),
		.dl_i         (dl_i),
		.core_ctrl_o  (core_ctrl_o),
		.joy_a_o      (joy_a_o),
		.joy_b_o      (joy_b_o),
		.dl_o         (dl_q),
		.rst_req_o    (rst_req),
		.host_rst_o   (host_rst)
	);

	reset_sequencer u_reset (
		.clk_sys      (clk_sys),
		.reset_delayed(reset_delayed),
		.dl_i         (dl_q),
		.rst_req_i    (rst_req),
		.host_rst_i   (host_rst),
		.hdd_mounted_i(hdd_mounted_i),
		.core_rstn_o  (core_rstn_o)
	);

	loader_write_buffer u_loader (
		.clk_sys      (clk_sys),
		.reset_delayed(reset_delayed),
		.dl_i         (dl_q),
		.ldr_ack_i    (ldr_ack_i),
		.ldr_o        (ldr_o)
	);

	audio_output u_audio (
		.clk_sys      (clk_sys),
		.reset_delayed(reset_delayed),
		.aud_l_i      (aud_l_i),
		.aud_r_i      (aud_r_i),
		.opm_ce_o     (opm_ce_o),
		.audio_l_o    (audio_l_o),
		.audio_r_o    (audio_r_o)
	);

endmodule

// ==== verilog/audio_output.sv ====
// Sound enables run from clk_sys; DAC outputs need an external RC low-pass filter
`timescale 1ns/1ps
`include "x68_defines.svh"

module audio_output (
	input  logic              clk_sys,
	input  logic              reset_delayed,
	input  core_pkg::sample_t aud_l_i,
	input  core_pkg::sample_t aud_r_i,
	output logic [1:0]        opm_ce_o,
	output logic              audio_l_o,
	output logic              audio_r_o
);

	localparam int OPM_CNT_W = $clog2(`OPM_DIV);
	localparam int CH_N      = 2;

	logic [`SND_DIV_W-1:0] snd_div;
	logic [OPM_CNT_W-1:0]  opm_div;
	logic                  opm_wrap;
	logic [`AUD_W-1:0]     smp_in [CH_N];
	logic [`AUD_W-1:0]     smp_q [CH_N];
	logic [`AUD_W-1:0]     acc_q [CH_N];
	logic [`AUD_W:0]       acc_sum [CH_N];
	logic [CH_N-1:0]       dac_q;

	//////////////////////////////////////////////////////////////////////
	// Sound chip clock enables
	assign opm_wrap = (opm_div == OPM_CNT_W'(`OPM_DIV - 1));

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			snd_div  <= '0;
			opm_div  <= '0;
			opm_ce_o <= '0;
		end else begin
			snd_div <= snd_div + 1'b1;
			if (opm_wrap)
				opm_div <= '0;
			else
				opm_div <= opm_div + 1'b1;
			opm_ce_o[0] <= (snd_div == '1);
			opm_ce_o[1] <= opm_wrap;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Delta-sigma DACs, channel 0 left and 1 right
	assign smp_in[0] = aud_l_i;
	assign smp_in[1] = aud_r_i;

	// Two's complement to offset binary
	always_ff @(posedge clk_sys) begin
		for (int ch = 0; ch < CH_N; ch++) begin
			smp_q[ch] <= {~smp_in[ch][`AUD_W-1], smp_in[ch][`AUD_W-2:0]};
		end
	end

	always_comb begin
		for (int ch = 0; ch < CH_N; ch++) begin
			acc_sum[ch] = {1'b0, acc_q[ch]} + {1'b0, smp_q[ch]};
		end
	end

	// Carry out is the one-bit output, its density tracks the sample
	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			acc_q <= '{default: '0};
			dac_q <= '0;
		end else begin
			for (int ch = 0; ch < CH_N; ch++) begin
				acc_q[ch] <= acc_sum[ch][`AUD_W-1:0];
				dac_q[ch] <= acc_sum[ch][`AUD_W];
			end
		end
	end

	assign audio_l_o = dac_q[0];
	assign audio_r_o = dac_q[1];

endmodule

// ==== verilog/loader_write_buffer.sv ====
// One byte deep; a strobe while a write is still pending overwrites the held byte
`timescale 1ns/1ps
`include "x68_defines.svh"

module loader_write_buffer (
	input  logic               clk_sys,
	input  logic               reset_delayed,
	input  host_pkg::dl_in_t   dl_i,
	input  logic               ldr_ack_i,
	output core_pkg::ldr_req_t ldr_o
);

	logic                   ack_q;
	logic                   ack_d;
	logic                   dl_d;
	logic                   wr_q;
	logic                   done_q;
	logic                   aen_q;
	logic [`LDR_ADDR_W-1:0] addr_q;
	logic [7:0]             data_q;
	logic                   ack_rise;
	logic                   dl_fall;
	logic                   strobe;

	assign ack_rise = ack_q & ~ack_d;
	assign dl_fall  = dl_d & ~dl_i.download;
	// Writes after the end of the download are ignored
	assign strobe   = dl_i.wr & ~done_q;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			ack_q  <= 1'b0;
			ack_d  <= 1'b0;
			dl_d   <= 1'b0;
			wr_q   <= 1'b0;
			done_q <= 1'b0;
			aen_q  <= 1'b0;
		end else begin
			ack_q <= ldr_ack_i;
			ack_d <= ack_q;
			dl_d  <= dl_i.download;

			// New strobe wins over the ack clear
			if (strobe)
				wr_q <= 1'b1;
			else if (ack_rise & wr_q)
				wr_q <= 1'b0;

			if (dl_fall)
				done_q <= 1'b1;

			aen_q <= dl_i.download & ~done_q;
		end
	end

	// Payload, captured with each strobe
	always_ff @(posedge clk_sys) begin
		if (strobe) begin
			addr_q <= dl_i.addr[`LDR_ADDR_W-1:0];
			data_q <= dl_i.data;
		end
	end

	assign ldr_o = '{aen: aen_q, wr: wr_q, done: done_q, addr: addr_q, data: data_q};

endmodule

// ==== verilog/reset_sequencer.sv ====
// Core stays in reset until a download starts and the host reset bit has fallen once
`timescale 1ns/1ps
`include "x68_defines.svh"

module reset_sequencer (
	input  logic             clk_sys,
	input  logic             reset_delayed,
	input  host_pkg::dl_in_t dl_i,
	input  logic             rst_req_i,
	input  logic             host_rst_i,
	input  logic             hdd_mounted_i,
	output logic             core_rstn_o
);

	logic               dl_d;
	logic               host_rst_d;
	logic               mounted_d;
	logic               dl_seen;
	logic               host_init;
	logic [`HOLD_W-1:0] hold_cnt;
	logic               dl_rise;
	logic               host_fall;
	logic               mount_rise;
	logic               hold_run;

	assign dl_rise    = ~dl_d & dl_i.download;
	assign host_fall  = host_rst_d & ~host_rst_i;
	assign mount_rise = ~mounted_d & hdd_mounted_i;
	assign hold_run   = |hold_cnt;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			dl_d        <= 1'b0;
			host_rst_d  <= 1'b0;
			mounted_d   <= 1'b0;
			dl_seen     <= 1'b0;
			host_init   <= 1'b0;
			hold_cnt    <= '0;
			core_rstn_o <= 1'b0;
		end else begin
			dl_d       <= dl_i.download;
			host_rst_d <= host_rst_i;
			mounted_d  <= hdd_mounted_i;

			// Both flags are sticky until the next system reset
			if (dl_rise)
				dl_seen <= 1'b1;
			if (host_fall)
				host_init <= 1'b1;

			// Fresh hard disk image restarts the long hold
			if (mount_rise)
				hold_cnt <= '1;
			else if (hold_run)
				hold_cnt <= hold_cnt - 1'b1;

			core_rstn_o <= dl_seen & host_init & ~rst_req_i & ~hold_run;
		end
	end

endmodule

// ==== verilog/host_ctrl_decode.sv ====
// All host inputs must already be synchronous to clk_sys; every output lags its input by one cycle
`timescale 1ns/1ps

module host_ctrl_decode (
	input  logic                   clk_sys,
	input  logic                   reset_delayed,
	input  host_pkg::status_word_u status_i,
	input  logic [1:0]             buttons_i,
	input  host_pkg::joy_raw_t     joystick_0_i,
	input  host_pkg::joy_raw_t     joystick_1_i,
	input  host_pkg::dl_in_t       dl_i,
	output core_pkg::core_ctrl_t   core_ctrl_o,
	output core_pkg::joy_port_t    joy_a_o,
	output core_pkg::joy_port_t    joy_b_o,
	output host_pkg::dl_in_t       dl_o,
	output logic                   rst_req_o,
	output logic                   host_rst_o
);
	import host_pkg::*;
	import core_pkg::*;

	core_ctrl_t ctrl_next;
	joy_port_t  joy_0_map;
	joy_port_t  joy_1_map;

	// Fold bits press both directions of an axis
	function automatic joy_port_t map_joy(input joy_raw_t raw);
		joy_port_t port;
		port = ~{raw.btn, raw.right | raw.h_fold, raw.left | raw.h_fold,
			raw.down | raw.v_fold, raw.up | raw.v_fold};
		return port;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Settings decode
	always_comb begin
		ctrl_next.fm_mode   = status_i.opt.fm_mode;
		ctrl_next.midi_mute = ~status_i.opt.midi_unmute;
		ctrl_next.tone_mode = status_i.opt.tone_mode;
		ctrl_next.fdd_wait  = status_i.opt.fdd_wait;
		ctrl_next.kbd_type  = status_i.opt.kbd_type;
		// Panel switches go active low
		ctrl_next.nmi_n     = ~status_i.trig.nmi;
		ctrl_next.power_n   = ~status_i.trig.power;
		ctrl_next.sram_ld   = status_i.trig.sram_load;
		ctrl_next.sram_st   = status_i.trig.sram_save;
	end

	assign joy_0_map = map_joy(joystick_0_i);
	assign joy_1_map = map_joy(joystick_1_i);

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			core_ctrl_o <= '{nmi_n: 1'b1, power_n: 1'b1, default: '0};
			joy_a_o     <= '1;
			joy_b_o     <= '1;
			rst_req_o   <= 1'b0;
			host_rst_o  <= 1'b0;
		end else begin
			core_ctrl_o <= ctrl_next;
			// Port A takes joystick 1 unless the swap bit is set
			if (status_i.opt.joy_swap) begin
				joy_a_o <= joy_0_map;
				joy_b_o <= joy_1_map;
			end else begin
				joy_a_o <= joy_1_map;
				joy_b_o <= joy_0_map;
			end
			rst_req_o  <= buttons_i[1] | status_i.trig.reset;
			host_rst_o <= status_i.trig.reset;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Download register toward loader and reset logic
	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			dl_o.download <= 1'b0;
			dl_o.wr       <= 1'b0;
		end else begin
			dl_o.download <= dl_i.download;
			dl_o.wr       <= dl_i.wr;
		end
	end

	always_ff @(posedge clk_sys) begin
		dl_o.addr <= dl_i.addr;
		dl_o.data <= dl_i.data;
	end

endmodule

// ==== verilog/core_pkg.sv ====
// Core side types; switches and joystick ports are active low as the core expects
`include "x68_defines.svh"

package core_pkg;

	// Settings and momentary switches for the emulator core
	typedef struct packed {
		logic       fm_mode;
		logic       midi_mute;
		logic [1:0] tone_mode;
		logic [1:0] fdd_wait;
		logic [1:0] kbd_type;
		logic       nmi_n;
		logic       power_n;
		logic       sram_ld;
		logic       sram_st;
	} core_ctrl_t;

	// Buttons 5:4, right, left, down, up, all active low
	typedef logic [`JOY_PORT_W-1:0] joy_port_t;

	// Loader write request toward core memory
	typedef struct packed {
		logic                   aen;
		logic                   wr;
		logic                   done;
		logic [`LDR_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} ldr_req_t;

	typedef logic signed [`AUD_W-1:0] sample_t;

endpackage

// ==== verilog/host_pkg.sv ====
// Host side types; status bit positions follow the host menu layout and must not move
`include "x68_defines.svh"

package host_pkg;

	// Momentary menu triggers
	typedef struct packed {
		logic [`STATUS_W-1:15] rsv_hi;
		logic                  sram_save;
		logic                  sram_load;
		logic [12:9]           rsv_mid;
		logic                  power;
		logic                  nmi;
		logic [6:1]            rsv_lo;
		logic                  reset;
	} status_trig_t;

	// Persistent menu options, bit 13 doubles as SRAM load
	typedef struct packed {
		logic [`STATUS_W-1:17] rsv_hi;
		logic [1:0]            kbd_type;
		logic                  rsv_14;
		logic [1:0]            fdd_wait;
		logic [1:0]            tone_mode;
		logic [9:7]            rsv_mid;
		logic                  joy_swap;
		logic [5:4]            rsv_lo;
		logic                  midi_unmute;
		logic                  rsv_2;
		logic                  fm_mode;
		logic                  rsv_0;
	} status_opt_t;

	typedef union packed {
		status_trig_t trig;
		status_opt_t  opt;
	} status_word_u;

	// Raw joystick, active high
	typedef struct packed {
		logic [`JOY_RAW_W-1:8] rsv;
		logic                  v_fold;
		logic                  h_fold;
		logic [1:0]            btn;
		logic                  up;
		logic                  down;
		logic                  left;
		logic                  right;
	} joy_raw_t;

	typedef struct packed {
		logic        download;
		logic        wr;
		logic [23:0] addr;
		logic [7:0]  data;
	} dl_in_t;

endpackage

// ==== include/x68_defines.svh ====
// Widths and counts shared by the glue logic; HOLD_W and OPM_DIV set reset and sound timing
`ifndef X68_DEFINES_SVH
`define X68_DEFINES_SVH

// Host side
`define STATUS_W 64
`define JOY_RAW_W 16

// Core side
`define JOY_PORT_W 6
`define AUD_W 16
`define LDR_ADDR_W 20

// Mount reset hold, the counter loads all ones
`define HOLD_W 16

// Divided sound enable period in clk_sys cycles
`define OPM_DIV 20

// Free sound divider, period is 2**SND_DIV_W
`define SND_DIV_W 4

`endif
